/* data_mem_port.sv */
module data_mem_port (
    input  logic              clk,
    input  logic              reset,
    input  lsu_pkg::mem_req_t mem_req,
    output lsu_pkg::bcast_t   load_bcast
);

    lsu_pkg::data_t mem [lsu_pkg::mem_words];

    logic [7:0]     idx;
    logic [3:0]     byte_en;
    lsu_pkg::data_t lane_wdata;
    lsu_pkg::data_t rd_word;
    lsu_pkg::data_t rd_shift;
    lsu_pkg::data_t rd_value;

    initial begin
        for (int i = 0; i < lsu_pkg::mem_words; i++) begin
            mem[i] = '0;
        end
    end

    assign idx = mem_req.addr[9:2];

    always_comb begin
        case (mem_req.size)
            lsu_pkg::size_byte: begin
                byte_en    = 4'b0001 << mem_req.addr[1:0];
                lane_wdata = {4{mem_req.wdata[7:0]}};
            end
            lsu_pkg::size_half: begin
                byte_en    = 4'b0011 << {mem_req.addr[1], 1'b0};
                lane_wdata = {2{mem_req.wdata[15:0]}};
            end
            default: begin
                byte_en    = 4'b1111;
                lane_wdata = mem_req.wdata;
            end
        endcase
    end

    assign rd_word  = mem[idx];
    assign rd_shift = rd_word >> {mem_req.addr[1:0], 3'b000};   // lane down to bit 0

    always_comb begin
        case (mem_req.size)
            lsu_pkg::size_byte:
                rd_value = {{24{mem_req.sign_ext & rd_shift[7]}}, rd_shift[7:0]};
            lsu_pkg::size_half:
                rd_value = {{16{mem_req.sign_ext & rd_shift[15]}}, rd_shift[15:0]};
            default:
                rd_value = rd_word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_req.valid && mem_req.is_store) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) mem[idx][8*b +: 8] <= lane_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            load_bcast.valid <= 1'b0;
        end else begin
            load_bcast.valid <= mem_req.valid && !mem_req.is_store;   // stores stay silent
            load_bcast.tag   <= mem_req.tag;
            load_bcast.value <= rd_value;
        end
    end

endmodule

/* load_store_buffer.sv */
module load_store_buffer (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  logic                new_valid,
    input  lsu_pkg::tag_t       new_tag,
    input  lsu_pkg::buf_entry_t new_entry,
    input  lsu_pkg::bcast_t     ex_bcast,
    input  lsu_pkg::bcast_t     load_bcast,
    input  logic                commit_valid,
    input  lsu_pkg::tag_t       commit_tag,
    output lsu_pkg::mem_req_t   mem_req,
    output logic                full
);

    localparam int n = lsu_pkg::num_entries;

    lsu_pkg::buf_entry_t entries [n];
    logic [n-1:0]        occupied, occupied_next;
    logic [n-1:0]        issued, issued_next;

    logic                commit_ok;
    logic                load_found;
    lsu_pkg::tag_t       load_idx;
    lsu_pkg::tag_t       sel_tag;
    lsu_pkg::buf_entry_t sel;
    lsu_pkg::mem_req_t   req_next;
    logic                load_done;

    // capture a broadcast value into any waiting operand with that tag
    function automatic lsu_pkg::buf_entry_t wake(input lsu_pkg::buf_entry_t e,
                                                 input lsu_pkg::bcast_t b);
        lsu_pkg::buf_entry_t r;
        r = e;
        if (b.valid && !e.base_rdy && e.base_tag == b.tag) begin
            r.base_rdy = 1'b1;
            r.base_val = b.value;
        end
        if (b.valid && !e.data_rdy && e.data_tag == b.tag) begin
            r.data_rdy = 1'b1;
            r.data_val = b.value;
        end
        return r;
    endfunction

    assign commit_ok = commit_valid && occupied[commit_tag] && entries[commit_tag].is_store
                       && entries[commit_tag].base_rdy && entries[commit_tag].data_rdy;

    // only an issued load may be retired, stale results after a flush are ignored
    assign load_done = load_bcast.valid && occupied[load_bcast.tag] && issued[load_bcast.tag];

    always_comb begin
        load_found = 1'b0;
        load_idx   = '0;
        for (int i = n - 1; i >= 1; i--) begin   // lowest ready index wins
            if (occupied[i] && !issued[i] && !entries[i].is_store && entries[i].base_rdy) begin
                load_found = 1'b1;
                load_idx   = lsu_pkg::tag_t'(i);
            end
        end
    end

    assign sel_tag = commit_ok ? commit_tag : load_idx;
    assign sel     = entries[sel_tag];

    always_comb begin
        req_next.valid    = commit_ok || load_found;
        req_next.is_store = sel.is_store;
        req_next.size     = sel.size;
        req_next.sign_ext = sel.sign_ext;
        req_next.tag      = sel_tag;
        req_next.addr     = sel.base_val + {{20{sel.imm[11]}}, sel.imm};
        req_next.wdata    = sel.data_val;
    end

    always_comb begin
        occupied_next = occupied;
        issued_next   = issued;
        if (load_done) begin
            occupied_next[load_bcast.tag] = 1'b0;
            issued_next[load_bcast.tag]   = 1'b0;
        end
        if (commit_ok) begin
            occupied_next[commit_tag] = 1'b0;   // store leaves at commit
        end else if (load_found) begin
            issued_next[load_idx] = 1'b1;
        end
        if (new_valid) begin
            occupied_next[new_tag] = 1'b1;
            issued_next[new_tag]   = 1'b0;
        end
        if (flush) begin
            occupied_next = '0;
            issued_next   = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            occupied <= '0;
            issued   <= '0;
            full     <= 1'b0;
        end else begin
            occupied <= occupied_next;
            issued   <= issued_next;
            full     <= &occupied_next[n-1:1];
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 1; i < n; i++) begin
            entries[i] <= wake(wake(entries[i], ex_bcast), load_bcast);
        end
        if (new_valid) begin
            entries[new_tag] <= wake(new_entry, load_bcast);   // ex_bcast handled in dispatch
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            mem_req.valid <= 1'b0;
        end else begin
            mem_req <= req_next;
        end
    end

endmodule

/* lsu.f */
lsu_pkg.sv
lsu_dispatch.sv
load_store_buffer.sv
data_mem_port.sv
lsu_top.sv
tb_lsu.sv

/* lsu_dispatch.sv */
module lsu_dispatch (
    input  lsu_pkg::dispatch_t  dispatch,
    input  lsu_pkg::bcast_t     ex_bcast,
    output logic                new_valid,
    output lsu_pkg::tag_t       new_tag,
    output lsu_pkg::buf_entry_t new_entry
);

    lsu_pkg::mem_op_e op;
    logic             is_mem;
    logic             base_hit;
    logic             data_hit;

    assign op      = lsu_pkg::mem_op_e'(dispatch.op[2:0]);
    assign is_mem  = !dispatch.op[3];   // upper half of the code space is non-memory
    assign new_tag = dispatch.tag;

    // same-cycle execute result, would otherwise be missed by the buffer
    assign base_hit = ex_bcast.valid && ex_bcast.tag == dispatch.base_tag;
    assign data_hit = ex_bcast.valid && ex_bcast.tag == dispatch.store_tag;

    always_comb begin
        new_valid          = dispatch.valid && is_mem;
        new_entry          = '0;
        new_entry.is_store = op inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw};
        new_entry.sign_ext = op inside {lsu_pkg::op_lb, lsu_pkg::op_lh};
        new_entry.imm      = dispatch.imm;

        case (op)
            lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb: new_entry.size = lsu_pkg::size_byte;
            lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh: new_entry.size = lsu_pkg::size_half;
            default: new_entry.size = lsu_pkg::size_word;
        endcase

        new_entry.base_tag = dispatch.base_tag;
        new_entry.base_val = dispatch.base_val;
        new_entry.base_rdy = dispatch.base_tag == '0;
        if (!new_entry.base_rdy && base_hit) begin
            new_entry.base_rdy = 1'b1;
            new_entry.base_val = ex_bcast.value;
        end

        new_entry.data_tag = dispatch.store_tag;
        new_entry.data_val = dispatch.store_val;
        new_entry.data_rdy = !new_entry.is_store || dispatch.store_tag == '0;   // loads need no data
        if (!new_entry.data_rdy && data_hit) begin
            new_entry.data_rdy = 1'b1;
            new_entry.data_val = ex_bcast.value;
        end
    end

endmodule

/* lsu_pkg.sv */
package lsu_pkg;

    localparam int tag_w       = 4;
    localparam int num_entries = 2 ** tag_w;   // entry 0 stays empty, tag 0 = no dependency
    localparam int raw_op_w    = 4;
    localparam int mem_words   = 256;

    typedef logic [tag_w-1:0] tag_t;
    typedef logic [31:0]      data_t;
    typedef logic [31:0]      addr_t;
    typedef logic [11:0]      imm_t;

    // codes 8..15 of the raw op are not memory ops
    typedef enum logic [2:0] {
        op_lb  = 3'd0,
        op_lh  = 3'd1,
        op_lw  = 3'd2,
        op_lbu = 3'd3,
        op_lhu = 3'd4,
        op_sb  = 3'd5,
        op_sh  = 3'd6,
        op_sw  = 3'd7
    } mem_op_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_e;

    typedef struct packed {
        logic                valid;
        logic [raw_op_w-1:0] op;
        tag_t                tag;
        tag_t                base_tag;
        data_t               base_val;
        tag_t                store_tag;
        data_t               store_val;
        imm_t                imm;
    } dispatch_t;

    typedef struct packed {
        logic  is_store;
        size_e size;
        logic  sign_ext;
        logic  base_rdy;
        tag_t  base_tag;
        data_t base_val;
        logic  data_rdy;
        tag_t  data_tag;
        data_t data_val;
        imm_t  imm;
    } buf_entry_t;

    typedef struct packed {
        logic  valid;
        logic  is_store;
        size_e size;
        logic  sign_ext;
        tag_t  tag;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // execute results and load results share this
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t value;
    } bcast_t;

endpackage

/* lsu_top.sv */
module lsu_top (
    input  logic               clk,
    input  logic               reset,
    input  lsu_pkg::dispatch_t dispatch,
    input  lsu_pkg::bcast_t    ex_bcast,
    input  logic               commit_valid,
    input  lsu_pkg::tag_t      commit_tag,
    input  logic               flush,
    output lsu_pkg::bcast_t    load_bcast,
    output logic               full
);

    logic                new_valid;
    lsu_pkg::tag_t       new_tag;
    lsu_pkg::buf_entry_t new_entry;
    lsu_pkg::mem_req_t   mem_req;

    lsu_dispatch u_dispatch (
        .dispatch  (dispatch),
        .ex_bcast  (ex_bcast),
        .new_valid (new_valid),
        .new_tag   (new_tag),
        .new_entry (new_entry)
    );

    // load results loop back for wakeup and to free the entry
    load_store_buffer u_buffer (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .new_valid    (new_valid),
        .new_tag      (new_tag),
        .new_entry    (new_entry),
        .ex_bcast     (ex_bcast),
        .load_bcast   (load_bcast),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .mem_req      (mem_req),
        .full         (full)
    );

    data_mem_port u_mem (
        .clk        (clk),
        .reset      (reset),
        .mem_req    (mem_req),
        .load_bcast (load_bcast)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_lsu -f lsu.f -o tb_lsu
./obj_dir/tb_lsu | tee sim.log

if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* tb_lsu.sv */
module tb_lsu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_random   = 80;
    localparam int num_ops    = n_random + 70;   // random ops plus the flush and full tests
    localparam int max_cycles = 40 * num_ops + 200;
    localparam lsu_pkg::tag_t ex_tag = 4'd15;    // producer on the execute side

    logic               clk;
    logic               reset;
    lsu_pkg::dispatch_t dispatch;
    lsu_pkg::bcast_t    ex_bcast;
    logic               commit_valid;
    lsu_pkg::tag_t      commit_tag;
    logic               flush;
    lsu_pkg::bcast_t    load_bcast;
    logic               full;

    bit [31:0] seed = 32'hcce4;
    bit [31:0] model_mem [256];
    bit [31:0] exp_val [16];
    bit [15:0] live;         // loads still owed a broadcast
    bit [15:0] waiting_ex;   // base not yet sent on ex_bcast
    bit [15:0] flushed;
    int        cycles;
    int        value_errors;
    int        other_errors;

    lsu_top dut (
        .clk          (clk),
        .reset        (reset),
        .dispatch     (dispatch),
        .ex_bcast     (ex_bcast),
        .commit_valid (commit_valid),
        .commit_tag   (commit_tag),
        .flush        (flush),
        .load_bcast   (load_bcast),
        .full         (full)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: test did not finish within %0d cycles", max_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic bit [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic bit [31:0] sext12(input bit [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic bit [31:0] model_load(input bit [31:0] addr, input bit [2:0] op);
        bit [31:0] sh;
        sh = model_mem[addr[9:2]] >> {addr[1:0], 3'b000};
        case (op)
            lsu_pkg::op_lb:  return {{24{sh[7]}}, sh[7:0]};
            lsu_pkg::op_lbu: return {24'd0, sh[7:0]};
            lsu_pkg::op_lh:  return {{16{sh[15]}}, sh[15:0]};
            lsu_pkg::op_lhu: return {16'd0, sh[15:0]};
            default:         return model_mem[addr[9:2]];
        endcase
    endfunction

    task automatic model_store(input bit [31:0] addr, input bit [2:0] op, input bit [31:0] data);
        int nbytes;
        int lane;
        nbytes = (op == lsu_pkg::op_sb) ? 1 : (op == lsu_pkg::op_sh) ? 2 : 4;
        for (int b = 0; b < nbytes; b++) begin
            lane = int'(addr[1:0]) + b;
            model_mem[addr[9:2]][8*lane +: 8] = data[8*b +: 8];
        end
    endtask

    // 16-word window so loads see stored data, aligned to the access size
    function automatic bit [31:0] rand_addr(input bit [2:0] op);
        bit [31:0] a;
        a = (lcg() >> 10) & 32'h3f;
        if (op == lsu_pkg::op_lw || op == lsu_pkg::op_sw) begin
            a[1:0] = 2'b00;
        end else if (op inside {lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh}) begin
            a[0] = 1'b0;
        end
        return a;
    endfunction

    function automatic lsu_pkg::tag_t free_tag();
        lsu_pkg::tag_t t;
        t = lsu_pkg::tag_t'(lcg() >> 28);
        repeat (16) begin
            if (t != 4'd0 && t != ex_tag && !live[t]) begin
                return t;
            end
            t++;
        end
        return 4'd0;
    endfunction

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            value_errors++;
            $display("FAIL at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_bcast(input logic in_flush);
        if (load_bcast.valid) begin
            if (live[load_bcast.tag]) begin
                if (waiting_ex[load_bcast.tag]) begin
                    other_errors++;
                    $display("load tag %0d returned before its base was broadcast", load_bcast.tag);
                end
                compare(load_bcast.value, exp_val[load_bcast.tag],
                        $sformatf("load tag %0d", load_bcast.tag));
                live[load_bcast.tag] = 1'b0;
            end else if (!(in_flush && flushed[load_bcast.tag])) begin
                other_errors++;
                $display("unexpected load broadcast for tag %0d at %0d ns", load_bcast.tag, $time);
            end
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
        check_bcast(flush);   // flush still shows the cycle just sampled
        dispatch.valid = 1'b0;
        ex_bcast.valid = 1'b0;
        commit_valid   = 1'b0;
        flush          = 1'b0;
    endtask

    task automatic send_load(input lsu_pkg::tag_t tag, input bit [2:0] op,
                             input lsu_pkg::tag_t base_tag, input bit [31:0] base_val,
                             input bit [11:0] imm, input bit [31:0] addr);
        dispatch           = '0;
        dispatch.valid     = 1'b1;
        dispatch.op        = {1'b0, op};
        dispatch.tag       = tag;
        dispatch.base_tag  = base_tag;
        dispatch.base_val  = base_val;
        dispatch.store_val = lcg();
        dispatch.imm       = imm;
        exp_val[tag]       = model_load(addr, op);
        live[tag]          = 1'b1;
        flushed[tag]       = 1'b0;
    endtask

    task automatic send_store(input lsu_pkg::tag_t tag, input bit [2:0] op, input bit [31:0] addr,
                              input bit [31:0] data, input bit data_waits);
        bit [11:0] imm;
        imm                = 12'(lcg() >> 20);
        dispatch           = '0;
        dispatch.valid     = 1'b1;
        dispatch.op        = {1'b0, op};
        dispatch.tag       = tag;
        dispatch.base_val  = addr - sext12(imm);
        dispatch.imm       = imm;
        dispatch.store_tag = data_waits ? ex_tag : 4'd0;
        dispatch.store_val = data_waits ? ~data : data;
    endtask

    task automatic broadcast_ex(input bit [31:0] value);
        ex_bcast.valid = 1'b1;
        ex_bcast.tag   = ex_tag;
        ex_bcast.value = value;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (live != '0 && waited < 60) begin
            tick();
            waited++;
        end
        for (int t = 1; t < 16; t++) begin
            if (live[t]) begin
                other_errors++;
                $display("load tag %0d never returned a result", t);
            end
        end
        live       = '0;
        waiting_ex = '0;
    endtask

    task automatic random_op();
        bit [31:0]     r;
        bit [31:0]     addr;
        bit [31:0]     data;
        bit [11:0]     imm;
        bit [2:0]      op;
        lsu_pkg::tag_t t;
        lsu_pkg::tag_t t2;
        r = lcg();
        if ($countones(live) > 11) begin
            drain();
        end
        t   = free_tag();
        imm = 12'(lcg() >> 20);
        op  = 3'((r >> 12) % 5);
        case (r[10:8])
            3'd0, 3'd1: begin
                addr = rand_addr(op);
                send_load(t, op, 4'd0, addr - sext12(imm), imm, addr);
                tick();
            end
            3'd2, 3'd3: begin   // base arrives on ex_bcast, maybe in the dispatch cycle
                addr = rand_addr(op);
                send_load(t, op, ex_tag, ~addr, imm, addr);
                waiting_ex[t] = r[16];
                if (!r[16]) begin
                    broadcast_ex(addr - sext12(imm));
                end
                tick();
                if (r[16]) begin
                    repeat (r[18:17]) tick();
                    broadcast_ex(addr - sext12(imm));
                    waiting_ex[t] = 1'b0;
                    tick();
                end
            end
            3'd4, 3'd5: begin   // second load uses the first one's result as base
                addr = rand_addr(lsu_pkg::op_lw);
                send_load(t, lsu_pkg::op_lw, 4'd0, addr - sext12(imm), imm, addr);
                tick();
                t2  = free_tag();
                op  = r[12] ? lsu_pkg::op_lb : lsu_pkg::op_lbu;
                imm = 12'(lcg() >> 20);
                send_load(t2, op, t, lcg(), imm, exp_val[t] + sext12(imm));
                tick();
            end
            3'd6: begin
                drain();
                op   = 3'(5 + (r >> 12) % 3);
                addr = rand_addr(op);
                data = lcg();
                send_store(t, op, addr, data, r[16]);
                tick();
                commit_valid = 1'b1;   // wrong tag, store must stay
                commit_tag   = t ^ 4'd1;
                tick();
                if (r[16]) begin
                    broadcast_ex(data);
                    tick();
                end
                if (r[17]) begin   // dropped before commit so memory keeps the old word
                    flush = 1'b1;
                    tick();
                end else begin
                    commit_valid = 1'b1;
                    commit_tag   = t;
                    tick();
                    model_store(addr, op, data);
                end
                tick();
                send_load(t, lsu_pkg::op_lw, 4'd0, addr & ~32'd3, 12'd0, addr & ~32'd3);
                tick();
            end
            default: begin   // non-memory code, dropped at dispatch
                send_load(t, lsu_pkg::op_lw, 4'd0, lcg(), 12'd0, 32'd0);
                dispatch.op = {1'b1, r[14:12]};
                live[t]     = 1'b0;
                tick();
            end
        endcase
    endtask

    task automatic flush_test();
        drain();
        for (int t = 7; t < 16; t++) begin   // parked on ex_tag to fill the buffer
            send_load(lsu_pkg::tag_t'(t), lsu_pkg::op_lw, ex_tag,
                      32'(4 * t), 12'd0, 32'(4 * t));
            tick();
        end
        for (int t = 1; t <= 6; t++) begin   // 1 to 4 wait forever, 5 reaches memory
            send_load(lsu_pkg::tag_t'(t), lsu_pkg::op_lw, t <= 4 ? ex_tag : 4'd0,
                      32'(4 * t), 12'd0, 32'(4 * t));
            tick();
        end
        compare(32'(full), 32'd1, "full before flush");
        flush      = 1'b1;
        flushed    = live;
        live       = '0;
        waiting_ex = '0;
        tick();
        repeat (4) tick();
        broadcast_ex(32'h40);
        repeat (8) tick();
        compare(32'(full), 32'd0, "full after flush");
        for (int t = 1; t <= 6; t++) begin
            send_load(lsu_pkg::tag_t'(t), lsu_pkg::op_lw, 4'd0, 32'(8 * t), 12'd0, 32'(8 * t));
            tick();
        end
        drain();
    endtask

    task automatic full_test();
        bit [31:0] addr [16];
        bit [31:0] data [16];
        bit [2:0]  ops [16];
        drain();
        for (int t = 1; t < 16; t++) begin
            ops[t]  = 3'(5 + (lcg() >> 8) % 3);
            addr[t] = rand_addr(ops[t]);
            data[t] = lcg();
            send_store(lsu_pkg::tag_t'(t), ops[t], addr[t], data[t], 1'b0);
            tick();
            if (t == 14) begin
                compare(32'(full), 32'd0, "full with 14 live entries");
            end
        end
        compare(32'(full), 32'd1, "full with 15 live entries");
        for (int t = 1; t < 16; t++) begin
            commit_valid = 1'b1;
            commit_tag   = lsu_pkg::tag_t'(t);
            tick();
            model_store(addr[t], ops[t], data[t]);
            if (t == 1) begin
                compare(32'(full), 32'd0, "full after first commit");
            end
        end
        tick();
        for (int t = 1; t < 16; t++) begin
            send_load(lsu_pkg::tag_t'(t), lsu_pkg::op_lw, 4'd0, addr[t] & ~32'd3, 12'd0,
                      addr[t] & ~32'd3);
            tick();
        end
        drain();
    endtask

    initial begin
        reset        = 1'b1;
        dispatch     = '0;
        ex_bcast     = '0;
        commit_valid = 1'b0;
        commit_tag   = 4'd0;
        flush        = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < n_random; i++) begin
            random_op();
        end
        flush_test();
        full_test();
        drain();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
